//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_dtm
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
hw/jtag_pkg.sv
hw/dmi_pkg.sv
hw/jtag_tap_ctrl.sv
hw/jtag_shift_reg.sv
hw/dtm_dr_chains.sv
hw/dmi_access.sv
hw/dtm_top.sv
testbench/tb_clock.sv
testbench/tb_dtm.sv

//--- hw/dmi_access.sv
`timescale 1ns/1ns

module dmi_access (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          dmi_update_i,
    input  dmi_pkg::dmi_reg_t             dmi_update_value_i,
    input  logic                          dmi_ack_i,
    input  logic [dmi_pkg::DMI_DBITS-1:0] dmi_rdata_i,
    output logic                          dmi_start_read_o,
    output logic                          dmi_start_write_o,
    output logic [dmi_pkg::DMI_ABITS-1:0] dmi_addr_o,
    output logic [dmi_pkg::DMI_DBITS-1:0] dmi_wdata_o,
    output dmi_pkg::dmi_reg_t             dmi_capture_value_o
);
    import dmi_pkg::*;

    logic                 req_read;
    logic                 req_write;
    logic                 busy_q;
    logic                 read_pend_q;
    logic                 start_read_q;
    logic                 start_write_q;
    logic [DMI_ABITS-1:0] addr_q;
    logic [DMI_DBITS-1:0] wdata_q;
    logic [DMI_DBITS-1:0] rdata_q;

    // new request only when nothing is in flight, nop and reserved ops ignored
    assign req_read  = dmi_update_i && !busy_q && (dmi_update_value_i.op == DMI_OP_READ);
    assign req_write = dmi_update_i && !busy_q && (dmi_update_value_i.op == DMI_OP_WRITE);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy_q        <= 1'b0;
            read_pend_q   <= 1'b0;
            start_read_q  <= 1'b0;
            start_write_q <= 1'b0;
        end
        else
        begin
            start_read_q  <= req_read;
            start_write_q <= req_write;
            // outstanding from start pulse until ack
            if (req_read || req_write)
            begin
                busy_q      <= 1'b1;
                read_pend_q <= req_read;
            end
            else if (dmi_ack_i)
            begin
                busy_q      <= 1'b0;
                read_pend_q <= 1'b0;
            end
        end
    end

    // addr and wdata hold until the next accepted request
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            addr_q  <= '0;
            wdata_q <= '0;
            rdata_q <= '0;
        end
        else
        begin
            if (req_read || req_write)
            begin
                addr_q  <= dmi_update_value_i.addr;
                wdata_q <= dmi_update_value_i.data;
            end
            // write acks carry no data
            if (dmi_ack_i && read_pend_q)
            begin
                rdata_q <= dmi_rdata_i;
            end
        end
    end

    // word loaded by the next capture-dr
    always_comb
    begin
        dmi_capture_value_o.addr = addr_q;
        dmi_capture_value_o.data = rdata_q;
        dmi_capture_value_o.op   = busy_q ? DMI_ST_BUSY : DMI_ST_SUCCESS;
    end

    assign dmi_start_read_o  = start_read_q;
    assign dmi_start_write_o = start_write_q;
    assign dmi_addr_o        = addr_q;
    assign dmi_wdata_o       = wdata_q;

    // the bus only acknowledges a request that is in flight
    a_ack_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        dmi_ack_i |-> busy_q)
        else $error("dmi acknowledge without outstanding request");

endmodule

//--- hw/dmi_pkg.sv
package dmi_pkg;

    // dmi field widths
    localparam int DMI_ABITS = 10;
    localparam int DMI_DBITS = 32;
    localparam int DMI_OP_W  = 2;

    // 44 bit dmi word, op in the two lowest bits
    typedef struct packed {
        logic [DMI_ABITS-1:0] addr;
        logic [DMI_DBITS-1:0] data;
        logic [DMI_OP_W-1:0]  op;
    } dmi_reg_t;

    // op field, towards the debug module
    localparam logic [DMI_OP_W-1:0] DMI_OP_NOP   = 2'd0;
    localparam logic [DMI_OP_W-1:0] DMI_OP_READ  = 2'd1;
    localparam logic [DMI_OP_W-1:0] DMI_OP_WRITE = 2'd2;

    // op field, status back to the debugger
    localparam logic [DMI_OP_W-1:0] DMI_ST_SUCCESS = 2'd0;
    localparam logic [DMI_OP_W-1:0] DMI_ST_BUSY    = 2'd3;

endpackage

//--- hw/dtm_dr_chains.sv
`timescale 1ns/1ns

module dtm_dr_chains #(
    parameter logic [jtag_pkg::IDCODE_W-1:0] IDCODE_VALUE = 32'h12345678
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tck_rise_i,
    input  logic             tlr_i,
    input  logic             tdi_i,
    input  logic             dr_capture_i,
    input  logic             dr_shift_i,
    input  logic             dr_update_i,
    input  jtag_pkg::ir_t    ir_value_i,
    input  dmi_pkg::dmi_reg_t dmi_capture_value_i,
    output logic             dr_tdo_o,
    output logic             dmi_update_o,
    output dmi_pkg::dmi_reg_t dmi_update_value_o
);
    import jtag_pkg::*;
    import dmi_pkg::*;

    logic                sel_idcode;
    logic                sel_dmi;
    logic                sel_bypass;
    logic [IDCODE_W-1:0] idcode_q;
    logic                bypass_q;
    logic                dmi_tdo;
    logic                dmi_update_q;

    // anything unknown falls back to bypass
    assign sel_idcode = (ir_value_i == INSTR_IDCODE);
    assign sel_dmi    = (ir_value_i == INSTR_DMI);
    assign sel_bypass = !sel_idcode && !sel_dmi;

    // idcode is read only, no update stage
    always_ff @(posedge clk)
    begin
        if (sel_idcode && dr_capture_i)
        begin
            idcode_q <= IDCODE_VALUE;
        end
        else if (sel_idcode && dr_shift_i)
        begin
            idcode_q <= {tdi_i, idcode_q[IDCODE_W-1:1]};
        end
    end

    // single bypass bit, leading 0
    always_ff @(posedge clk)
    begin
        if (sel_bypass && dr_capture_i)
        begin
            bypass_q <= 1'b0;
        end
        else if (sel_bypass && dr_shift_i)
        begin
            bypass_q <= tdi_i;
        end
    end

    // dmi chain only sees strobes while dmi is selected
    jtag_shift_reg #(
        .data_t      (dmi_reg_t),
        .RESET_VALUE ('0)
    ) u_dmi_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .tck_rise_i      (tck_rise_i),
        .clear_i         (tlr_i),
        .capture_i       (dr_capture_i && sel_dmi),
        .shift_i         (dr_shift_i && sel_dmi),
        .update_i        (dr_update_i && sel_dmi),
        .tdi_i           (tdi_i),
        .capture_value_i (dmi_capture_value_i),
        .tdo_bit_o       (dmi_tdo),
        .update_value_o  (dmi_update_value_o)
    );

    // delayed one cycle so the update stage already holds the new word
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dmi_update_q <= 1'b0;
        end
        else
        begin
            dmi_update_q <= dr_update_i && sel_dmi;
        end
    end

    assign dmi_update_o = dmi_update_q;

    // tdo source
    assign dr_tdo_o = sel_dmi    ? dmi_tdo     :
                      sel_idcode ? idcode_q[0] : bypass_q;

endmodule

//--- hw/dtm_top.sv
`timescale 1ns/1ns

module dtm_top #(
    parameter logic [jtag_pkg::IDCODE_W-1:0] IDCODE_VALUE = 32'h12345678
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tck_i,
    input  logic                          tms_i,
    input  logic                          tdi_i,
    input  logic                          dmi_ack_i,
    input  logic [dmi_pkg::DMI_DBITS-1:0] dmi_rdata_i,
    output logic                          tdo_o,
    output logic                          dmi_start_read_o,
    output logic                          dmi_start_write_o,
    output logic [dmi_pkg::DMI_ABITS-1:0] dmi_addr_o,
    output logic [dmi_pkg::DMI_DBITS-1:0] dmi_wdata_o
);
    import jtag_pkg::*;
    import dmi_pkg::*;

    logic     tdi_s;
    logic     tck_rise;
    logic     tlr;
    logic     ir_capture;
    logic     ir_shift;
    logic     ir_update;
    logic     dr_capture;
    logic     dr_shift;
    logic     dr_update;
    logic     ir_tdo;
    logic     dr_tdo;
    logic     dmi_update;
    ir_t      ir_value;
    dmi_reg_t dmi_update_value;
    dmi_reg_t dmi_capture_value;

    jtag_tap_ctrl u_tap (
        .clk          (clk),
        .rst_n        (rst_n),
        .tck_i        (tck_i),
        .tms_i        (tms_i),
        .tdi_i        (tdi_i),
        .ir_tdo_i     (ir_tdo),
        .dr_tdo_i     (dr_tdo),
        .tdi_o        (tdi_s),
        .tck_rise_o   (tck_rise),
        .tlr_o        (tlr),
        .ir_capture_o (ir_capture),
        .ir_shift_o   (ir_shift),
        .ir_update_o  (ir_update),
        .dr_capture_o (dr_capture),
        .dr_shift_o   (dr_shift),
        .dr_update_o  (dr_update),
        .tdo_o        (tdo_o)
    );

    // instruction register, capture returns the current instruction
    jtag_shift_reg #(
        .data_t      (ir_t),
        .RESET_VALUE (INSTR_IDCODE)
    ) u_ir (
        .clk             (clk),
        .rst_n           (rst_n),
        .tck_rise_i      (tck_rise),
        .clear_i         (tlr),
        .capture_i       (ir_capture),
        .shift_i         (ir_shift),
        .update_i        (ir_update),
        .tdi_i           (tdi_s),
        .capture_value_i (ir_value),
        .tdo_bit_o       (ir_tdo),
        .update_value_o  (ir_value)
    );

    dtm_dr_chains #(
        .IDCODE_VALUE (IDCODE_VALUE)
    ) u_dr (
        .clk                 (clk),
        .rst_n               (rst_n),
        .tck_rise_i          (tck_rise),
        .tlr_i               (tlr),
        .tdi_i               (tdi_s),
        .dr_capture_i        (dr_capture),
        .dr_shift_i          (dr_shift),
        .dr_update_i         (dr_update),
        .ir_value_i          (ir_value),
        .dmi_capture_value_i (dmi_capture_value),
        .dr_tdo_o            (dr_tdo),
        .dmi_update_o        (dmi_update),
        .dmi_update_value_o  (dmi_update_value)
    );

    dmi_access u_dmi (
        .clk                 (clk),
        .rst_n               (rst_n),
        .dmi_update_i        (dmi_update),
        .dmi_update_value_i  (dmi_update_value),
        .dmi_ack_i           (dmi_ack_i),
        .dmi_rdata_i         (dmi_rdata_i),
        .dmi_start_read_o    (dmi_start_read_o),
        .dmi_start_write_o   (dmi_start_write_o),
        .dmi_addr_o          (dmi_addr_o),
        .dmi_wdata_o         (dmi_wdata_o),
        .dmi_capture_value_o (dmi_capture_value)
    );

endmodule

//--- hw/jtag_pkg.sv
package jtag_pkg;

    // instruction register length, riscv debug spec minimum
    localparam int IR_WIDTH = 5;

    typedef logic [IR_WIDTH-1:0] ir_t;

    // instruction codes
    localparam ir_t INSTR_IDCODE = 5'h01;
    localparam ir_t INSTR_DMI    = 5'h11;
    localparam ir_t INSTR_BYPASS = 5'h1F;

    // idcode word width
    localparam int IDCODE_W = 32;

    // the sixteen tap states
    typedef enum logic [3:0] {
        TAP_RESET      = 4'h0,
        TAP_IDLE       = 4'h1,
        TAP_SELECT_DR  = 4'h2,
        TAP_CAPTURE_DR = 4'h3,
        TAP_SHIFT_DR   = 4'h4,
        TAP_EXIT1_DR   = 4'h5,
        TAP_PAUSE_DR   = 4'h6,
        TAP_EXIT2_DR   = 4'h7,
        TAP_UPDATE_DR  = 4'h8,
        TAP_SELECT_IR  = 4'h9,
        TAP_CAPTURE_IR = 4'hA,
        TAP_SHIFT_IR   = 4'hB,
        TAP_EXIT1_IR   = 4'hC,
        TAP_PAUSE_IR   = 4'hD,
        TAP_EXIT2_IR   = 4'hE,
        TAP_UPDATE_IR  = 4'hF
    } tap_state_t;

endpackage

//--- hw/jtag_shift_reg.sv
`timescale 1ns/1ns

module jtag_shift_reg #(
    parameter type   data_t      = jtag_pkg::ir_t,
    parameter data_t RESET_VALUE = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tck_rise_i,
    input  logic  clear_i,
    input  logic  capture_i,
    input  logic  shift_i,
    input  logic  update_i,
    input  logic  tdi_i,
    input  data_t capture_value_i,
    output logic  tdo_bit_o,
    output data_t update_value_o
);
    localparam int W = $bits(data_t);

    logic [W-1:0] shift_q;
    logic [W-1:0] update_q;

    // shift stage, lsb leaves first, tdi enters at the top
    always_ff @(posedge clk)
    begin
        if (clear_i)
        begin
            shift_q <= RESET_VALUE;
        end
        else if (capture_i)
        begin
            shift_q <= capture_value_i;
        end
        else if (shift_i)
        begin
            shift_q <= {tdi_i, shift_q[W-1:1]};
        end
    end

    // update stage is what the rest of the design sees
    always_ff @(posedge clk)
    begin
        if (!rst_n || clear_i)
        begin
            update_q <= RESET_VALUE;
        end
        else if (update_i)
        begin
            update_q <= shift_q;
        end
    end

    assign tdo_bit_o      = shift_q[0];
    assign update_value_o = data_t'(update_q);

    // every scan strobe has to coincide with a tck rise
    a_strobe_on_rise: assert property (@(posedge clk) disable iff (!rst_n)
        (capture_i || shift_i || update_i) |-> tck_rise_i)
        else $error("scan strobe without tck rise");

endmodule

//--- hw/jtag_tap_ctrl.sv
`timescale 1ns/1ns

module jtag_tap_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic tck_i,
    input  logic tms_i,
    input  logic tdi_i,
    input  logic ir_tdo_i,
    input  logic dr_tdo_i,
    output logic tdi_o,
    output logic tck_rise_o,
    output logic tlr_o,
    output logic ir_capture_o,
    output logic ir_shift_o,
    output logic ir_update_o,
    output logic dr_capture_o,
    output logic dr_shift_o,
    output logic dr_update_o,
    output logic tdo_o
);
    import jtag_pkg::*;

    logic       tck_s1;
    logic       tck_s2;
    logic       tck_q;
    logic [2:0] tms_sync;
    logic [2:0] tdi_sync;
    logic       tck_fall;
    logic       tck_rise_q;
    tap_state_t state_q;
    tap_state_t state_d;

    // two flop synchronizer plus edge register for tck
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tck_s1     <= 1'b0;
            tck_s2     <= 1'b0;
            tck_q      <= 1'b0;
            tck_rise_q <= 1'b0;
        end
        else
        begin
            tck_s1     <= tck_i;
            tck_s2     <= tck_s1;
            tck_q      <= tck_s2;
            tck_rise_q <= tck_s2 & ~tck_q;
        end
    end

    // tms and tdi get the same depth, so they line up with tck_rise_q
    always_ff @(posedge clk)
    begin
        tms_sync <= {tms_sync[1:0], tms_i};
        tdi_sync <= {tdi_sync[1:0], tdi_i};
    end

    // falling edge seen one stage early, tdo loads on it
    assign tck_fall = ~tck_s2 & tck_q;

    // standard tap transitions, sampled tms
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            TAP_RESET:      state_d = tms_sync[2] ? TAP_RESET : TAP_IDLE;
            TAP_IDLE:       state_d = tms_sync[2] ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  state_d = tms_sync[2] ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: state_d = tms_sync[2] ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   state_d = tms_sync[2] ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   state_d = tms_sync[2] ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   state_d = tms_sync[2] ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   state_d = tms_sync[2] ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  state_d = tms_sync[2] ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR:  state_d = tms_sync[2] ? TAP_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: state_d = tms_sync[2] ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   state_d = tms_sync[2] ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   state_d = tms_sync[2] ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   state_d = tms_sync[2] ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   state_d = tms_sync[2] ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  state_d = tms_sync[2] ? TAP_SELECT_DR : TAP_IDLE;
            default:        state_d = TAP_RESET;
        endcase
    end

    // state only steps on a tck rise
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= TAP_RESET;
        end
        else if (tck_rise_q)
        begin
            state_q <= state_d;
        end
    end

    // tdo follows the shifting chain, holds outside the shift states
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tdo_o <= 1'b0;
        end
        else if (tck_fall && state_q == TAP_SHIFT_IR)
        begin
            tdo_o <= ir_tdo_i;
        end
        else if (tck_fall && state_q == TAP_SHIFT_DR)
        begin
            tdo_o <= dr_tdo_i;
        end
    end

    // scan strobes, keyed to the state before the edge
    assign ir_capture_o = tck_rise_q && (state_q == TAP_CAPTURE_IR);
    assign ir_shift_o   = tck_rise_q && (state_q == TAP_SHIFT_IR);
    assign ir_update_o  = tck_rise_q && (state_q == TAP_UPDATE_IR);
    assign dr_capture_o = tck_rise_q && (state_q == TAP_CAPTURE_DR);
    assign dr_shift_o   = tck_rise_q && (state_q == TAP_SHIFT_DR);
    assign dr_update_o  = tck_rise_q && (state_q == TAP_UPDATE_DR);

    assign tck_rise_o = tck_rise_q;
    assign tlr_o      = (state_q == TAP_RESET);
    assign tdi_o      = tdi_sync[2];

    // tck must stay high for more than one clk after a rise
    a_rise_fall_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(tck_rise_q && tck_fall))
        else $error("tck rise and fall strobes overlap");

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);
    // 100 ns period
    initial
    begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held low for 8 rising edges
    initial
    begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- testbench/tb_dtm.sv
`timescale 1ns/1ns

module tb_dtm;
    import jtag_pkg::*;

    localparam logic [31:0] IDCODE_VALUE = 32'h2BA01477;
    // clk cycles per tck half period
    localparam int HALF = 8;
    // about six times the length of all tests together
    localparam int TIMEOUT_CYCLES = 60000;
    // longer than a full 44 bit dmi scan, so a second request lands while busy
    localparam int LONG_HOLD = 1500;
    localparam logic [9:0]  WR_ADDR = 10'h010;
    localparam logic [31:0] WR_DATA = 32'hCAFE1234;
    localparam logic [9:0]  ADDR2   = 10'h2C5;
    localparam logic [31:0] DATA2   = 32'h5A5AF00D;

    logic        clk;
    logic        rst_n;
    logic        tck_i;
    logic        tms_i;
    logic        tdi_i;
    logic        dmi_ack_i;
    logic [31:0] dmi_rdata_i;
    logic        tdo_o;
    logic        dmi_start_read_o;
    logic        dmi_start_write_o;
    logic [9:0]  dmi_addr_o;
    logic [31:0] dmi_wdata_o;

    // expected dtm state
    ir_t         model_ir;
    logic [9:0]  model_addr;
    logic [31:0] model_rdata;
    logic        model_busy;

    // pending scan results for the compare process
    string       name_q[$];
    logic [63:0] exp_q[$];
    logic [63:0] act_q[$];

    int          errors;
    int          checks;
    int          tests_passed;
    int          tests_failed;
    int          test_err_start;
    int          cycles;
    int          reads_seen;
    int          writes_seen;
    int          acks_seen;
    logic        hold_long;
    logic [31:0] mem [0:1023];

    tb_clock u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dtm_top #(
        .IDCODE_VALUE (IDCODE_VALUE)
    ) dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .tck_i             (tck_i),
        .tms_i             (tms_i),
        .tdi_i             (tdi_i),
        .dmi_ack_i         (dmi_ack_i),
        .dmi_rdata_i       (dmi_rdata_i),
        .tdo_o             (tdo_o),
        .dmi_start_read_o  (dmi_start_read_o),
        .dmi_start_write_o (dmi_start_write_o),
        .dmi_addr_o        (dmi_addr_o),
        .dmi_wdata_o       (dmi_wdata_o)
    );

    // expected bits out of a scan, lsb first
    function automatic logic [63:0] dtm_model(input logic is_ir, input logic [63:0] tdi_bits,
                                              input int n);
        logic [63:0] word;
        logic [63:0] mask;
        if (is_ir)
            word = {59'd0, model_ir};
        else if (model_ir == INSTR_IDCODE)
            word = {32'd0, IDCODE_VALUE};
        else if (model_ir == INSTR_DMI)
            word = {20'd0, model_addr, model_rdata, model_busy ? 2'd3 : 2'd0};
        else
            // bypass, one bit of delay after a leading 0
            word = {tdi_bits[62:0], 1'b0};
        mask = (n >= 64) ? '1 : ((64'd1 << n) - 64'd1);
        return word & mask;
    endfunction

    // one tck period, tdo sampled just before the rise
    task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
        @(posedge clk);
        tck_i <= 1'b0;
        tms_i <= tms;
        tdi_i <= tdi;
        repeat (HALF - 1) @(posedge clk);
        @(negedge clk);
        tdo = tdo_o;
        @(posedge clk);
        tck_i <= 1'b1;
        repeat (HALF - 1) @(posedge clk);
    endtask

    // idle to idle through shift-ir
    task automatic scan_ir(input ir_t instr, output ir_t captured);
        logic tdo;
        tck_cycle(1'b1, 1'b0, tdo);
        tck_cycle(1'b1, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, tdo);
        for (int i = 0; i < IR_WIDTH; i++)
        begin
            tck_cycle(i == IR_WIDTH - 1, instr[i], tdo);
            captured[i] = tdo;
        end
        tck_cycle(1'b1, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, tdo);
    endtask

    // idle to idle through shift-dr, n bits
    task automatic scan_dr(input logic [63:0] bits, input int n, output logic [63:0] captured);
        logic tdo;
        captured = '0;
        tck_cycle(1'b1, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, tdo);
        for (int i = 0; i < n; i++)
        begin
            tck_cycle(i == n - 1, bits[i], tdo);
            captured[i] = tdo;
        end
        tck_cycle(1'b1, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, tdo);
    endtask

    task automatic expect_scan(input string name, input logic [63:0] exp, input logic [63:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // immediate check of a dut output
    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic wait_bus_idle();
        int k;
        k = 0;
        while (acks_seen < reads_seen + writes_seen && k < 3 * LONG_HOLD)
        begin
            @(posedge clk);
            k++;
        end
        if (acks_seen < reads_seen + writes_seen)
        begin
            errors++;
            $display("bus acknowledge never arrived after %0d cycles", k);
        end
    endtask

    task automatic begin_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        // let the compare process drain
        repeat (2) @(posedge clk);
        if (errors == test_err_start)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_err_start);
        end
    endtask

    // compare process
    always @(posedge clk)
    begin
        string       nm;
        logic [63:0] e;
        logic [63:0] a;
        while (exp_q.size() > 0)
        begin
            nm = name_q.pop_front();
            e  = exp_q.pop_front();
            a  = act_q.pop_front();
            checks++;
            if (e !== a)
            begin
                errors++;
                $display("Mismatch at %0t: %s expected %h got %h", $time, nm, e, a);
            end
        end
    end

    // pulse counters on the bus side
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (dmi_start_read_o)
                reads_seen++;
            if (dmi_start_write_o)
                writes_seen++;
            if (dmi_ack_i)
                acks_seen++;
        end
    end

    // bus responder
    initial
    begin
        logic [9:0] addr;
        logic       is_read;
        int         delay;
        dmi_ack_i   = 1'b0;
        dmi_rdata_i = '0;
        // fill depends on the full 10 bit address
        for (int i = 0; i < 1024; i++)
            mem[i] = 32'hD00D0000 ^ (i * 32'h00010003);
        forever
        begin
            @(posedge clk);
            if (rst_n && (dmi_start_read_o || dmi_start_write_o))
            begin
                addr    = dmi_addr_o;
                is_read = dmi_start_read_o;
                if (!is_read)
                    mem[addr] = dmi_wdata_o;
                delay = hold_long ? LONG_HOLD : $urandom_range(20, 1);
                repeat (delay) @(posedge clk);
                dmi_rdata_i <= is_read ? mem[addr] : 32'h0;
                dmi_ack_i   <= 1'b1;
                @(posedge clk);
                dmi_ack_i   <= 1'b0;
            end
        end
    end

    // run limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial
    begin
        int unsigned seed;
        ir_t         ir_out;
        logic [63:0] bits;
        logic [63:0] out;
        logic        tdo_bit;
        int          r0;
        int          w0;
        seed = $urandom(73);
        tck_i = 1'b0;
        tms_i = 1'b1;
        tdi_i = 1'b0;
        hold_long = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        reads_seen = 0;
        writes_seen = 0;
        acks_seen = 0;
        tests_passed = 0;
        tests_failed = 0;
        model_ir = INSTR_IDCODE;
        model_addr = '0;
        model_rdata = '0;
        model_busy = 1'b0;
        @(posedge rst_n);
        repeat (4) @(posedge clk);
        // leave test-logic-reset
        tck_cycle(1'b0, 1'b0, tdo_bit);

        begin_test();
        bits = {$urandom, $urandom};
        scan_dr(bits, 32, out);
        expect_scan("tdo idcode", dtm_model(1'b0, bits, 32), out);
        end_test("1 idcode after reset");

        begin_test();
        scan_ir(INSTR_BYPASS, ir_out);
        expect_scan("tdo ir capture", dtm_model(1'b1, '0, IR_WIDTH), {59'd0, ir_out});
        model_ir = INSTR_BYPASS;
        bits = {$urandom, $urandom};
        scan_dr(bits, 24, out);
        expect_scan("tdo bypass", dtm_model(1'b0, bits, 24), out);
        // unused code falls back to bypass
        scan_ir(5'h05, ir_out);
        expect_scan("tdo ir capture", dtm_model(1'b1, '0, IR_WIDTH), {59'd0, ir_out});
        model_ir = 5'h05;
        bits = {$urandom, $urandom};
        scan_dr(bits, 24, out);
        expect_scan("tdo bypass unknown", dtm_model(1'b0, bits, 24), out);
        end_test("2 ir capture and bypass");

        begin_test();
        scan_ir(INSTR_DMI, ir_out);
        expect_scan("tdo ir capture", dtm_model(1'b1, '0, IR_WIDTH), {59'd0, ir_out});
        model_ir = INSTR_DMI;
        r0 = reads_seen;
        w0 = writes_seen;
        bits = {20'd0, WR_ADDR, WR_DATA, 2'd2};
        scan_dr(bits, 44, out);
        expect_scan("tdo dmi write", dtm_model(1'b0, bits, 44), out);
        repeat (4) @(posedge clk);
        check_value("dmi_start_write_o count", 64'd1, 64'(writes_seen - w0));
        check_value("dmi_start_read_o count", 64'd0, 64'(reads_seen - r0));
        check_value("dmi_addr_o", {54'd0, WR_ADDR}, {54'd0, dmi_addr_o});
        check_value("dmi_wdata_o", {32'd0, WR_DATA}, {32'd0, dmi_wdata_o});
        model_addr = WR_ADDR;
        wait_bus_idle();
        end_test("3 dmi write");

        begin_test();
        r0 = reads_seen;
        bits = {20'd0, WR_ADDR, 32'd0, 2'd1};
        scan_dr(bits, 44, out);
        expect_scan("tdo dmi read", dtm_model(1'b0, bits, 44), out);
        wait_bus_idle();
        model_rdata = WR_DATA;
        bits = '0;
        scan_dr(bits, 44, out);
        expect_scan("tdo dmi read data", dtm_model(1'b0, bits, 44), out);
        check_value("dmi_start_read_o count", 64'd1, 64'(reads_seen - r0));
        end_test("4 dmi read");

        begin_test();
        bits = {20'd0, ADDR2, DATA2, 2'd2};
        scan_dr(bits, 44, out);
        expect_scan("tdo dmi write", dtm_model(1'b0, bits, 44), out);
        model_addr = ADDR2;
        wait_bus_idle();
        hold_long = 1'b1;
        bits = {20'd0, ADDR2, 32'd0, 2'd1};
        scan_dr(bits, 44, out);
        expect_scan("tdo dmi read", dtm_model(1'b0, bits, 44), out);
        r0 = reads_seen;
        w0 = writes_seen;
        // read still unacknowledged, this request must be dropped
        model_busy = 1'b1;
        bits = {20'd0, 10'h3FF, 32'h11111111, 2'd2};
        scan_dr(bits, 44, out);
        expect_scan("tdo dmi busy", dtm_model(1'b0, bits, 44), out);
        repeat (4) @(posedge clk);
        check_value("extra dmi_start_write_o", 64'd0, 64'(writes_seen - w0));
        check_value("extra dmi_start_read_o", 64'd0, 64'(reads_seen - r0));
        wait_bus_idle();
        hold_long = 1'b0;
        model_busy = 1'b0;
        model_rdata = DATA2;
        bits = '0;
        scan_dr(bits, 44, out);
        expect_scan("tdo dmi after busy", dtm_model(1'b0, bits, 44), out);
        end_test("5 dmi busy");

        begin_test();
        scan_ir(INSTR_BYPASS, ir_out);
        expect_scan("tdo ir capture", dtm_model(1'b1, '0, IR_WIDTH), {59'd0, ir_out});
        model_ir = INSTR_BYPASS;
        // five tms high cycles reach test-logic-reset from anywhere
        for (int i = 0; i < 5; i++)
            tck_cycle(1'b1, 1'b0, tdo_bit);
        tck_cycle(1'b0, 1'b0, tdo_bit);
        model_ir = INSTR_IDCODE;
        bits = {$urandom, $urandom};
        scan_dr(bits, 32, out);
        expect_scan("tdo idcode after tlr", dtm_model(1'b0, bits, 32), out);
        end_test("6 tap reset");

        repeat (4) @(posedge clk);
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
